//--- sources.f
design/cluster_pkg.sv
design/dma_pkg.sv
design/dma_spill_register.sv
design/dma_row_splitter.sv
design/dma_group_distributor.sv
design/dma_completion_tracker.sv
design/dma_cluster_frontend.sv
sim/tb_dma_cluster_frontend.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_dma_cluster_frontend
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Finished with errors
PASS_MSG  := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_dma_cluster_frontend.sv
// Testbench for the cluster DMA front end
// Plays the group back ends and checks slicing, stalls and completion status
module tb_dma_cluster_frontend;
  import cluster_pkg::*;
  import dma_pkg::*;

  localparam int unsigned MaxSlices = 512;
  localparam int unsigned MaxXfers  = 64;

  logic                     clk_i;
  logic                     arst_n_i;
  dma_req_t                 dma_req_i;
  logic                     dma_req_valid_i;
  logic                     dma_req_ready_o;
  logic                     dma_busy_o;
  logic                     dma_done_o;
  dma_req_t [NumGroups-1:0] grp_req_o;
  logic [NumGroups-1:0]     grp_req_valid_o;
  logic [NumGroups-1:0]     grp_req_ready_i;
  logic [NumGroups-1:0]     grp_done_i;

  // Reference model of the expected slices per group
  dma_req_t exp_mem [NumGroups][MaxSlices];
  int       slice_xfer [NumGroups][MaxSlices];
  int       exp_wr [NumGroups];
  int       exp_rd [NumGroups];
  dma_req_t exp_head [NumGroups];
  int       xfer_left [MaxXfers];
  int       xfer_count;
  int       done_count;
  int       slice_total;
  int       error_count;
  int       error_base;
  int       tests_run;

  // Group back ends
  logic [NumGroups-1:0] hs_last;
  int                   pending [NumGroups];
  int                   done_rd [NumGroups];
  int                   done_wait [NumGroups];
  int                   ready_mode;
  logic [31:0]          stim_lfsr;
  logic [31:0]          grp_lfsr;

  logic idle_check;
  logic bp_end;
  logic drain_check;
  logic ready_seen;
  int   ready_wait;
  int   cycles;

  dma_cluster_frontend dma_cluster_frontend_inst (
    .clk_i          (clk_i          ),
    .arst_n_i       (arst_n_i       ),
    .dma_req_i      (dma_req_i      ),
    .dma_req_valid_i(dma_req_valid_i),
    .dma_req_ready_o(dma_req_ready_o),
    .dma_busy_o     (dma_busy_o     ),
    .dma_done_o     (dma_done_o     ),
    .grp_req_o      (grp_req_o      ),
    .grp_req_valid_o(grp_req_valid_o),
    .grp_req_ready_i(grp_req_ready_i),
    .grp_done_i     (grp_done_i     )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      state = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
      v = {v[30:0], state[0]};
    end
    return v;
  endfunction

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hs_last    <= '0;
      done_count <= 0;
      ready_seen <= 1'b0;
      ready_wait <= 0;
    end else begin
      hs_last <= grp_req_valid_o & grp_req_ready_i;
      for (int g = 0; g < NumGroups; g++) begin
        if (grp_req_valid_o[g] && grp_req_ready_i[g]) begin
          exp_rd[g] <= exp_rd[g] + 1;
        end
      end
      if (dma_done_o) begin
        done_count <= done_count + 1;
      end
      if (dma_req_ready_o) begin
        ready_seen <= 1'b1;
      end else if (!ready_seen) begin
        ready_wait <= ready_wait + 1;
      end
    end
  end

  // Each group finishes its slices in order after a random delay
  initial begin : group_back_ends
    grp_lfsr        = 32'hab29_6a6c;
    grp_req_ready_i = '0;
    grp_done_i      = '0;
    forever begin
      @(posedge clk_i);
      #1;
      grp_done_i = '0;
      for (int g = 0; g < NumGroups; g++) begin
        if (hs_last[g]) begin
          pending[g]++;
        end
        if (pending[g] > 0 && done_wait[g] == 0) begin
          grp_done_i[g] = 1'b1;
          xfer_left[slice_xfer[g][done_rd[g] % MaxSlices]]--;
          done_rd[g]++;
          pending[g]--;
          done_wait[g] = int'(take_bits(grp_lfsr, 3));
        end else if (pending[g] > 0) begin
          done_wait[g]--;
        end
      end
      case (ready_mode)
        0:       grp_req_ready_i = '1;
        1:       grp_req_ready_i = NumGroups'(take_bits(grp_lfsr, NumGroups));
        default: grp_req_ready_i = '0;
      endcase
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles <= 40 * slice_total + 200) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
    $display("Finished with errors");
    $finish;
  end

  a_idle : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    idle_check |-> (grp_req_valid_o == '0) && !dma_busy_o && !dma_done_o)
    else begin
      error_count++;
      $display("Outputs not idle after reset without stimulus");
    end

  a_ready_rise : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ready_wait != 4)
    else begin
      error_count++;
      $display("dma_req_ready_o did not rise after reset");
    end

  a_backpressure : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bp_end |-> !dma_req_ready_o)
    else begin
      error_count++;
      $display("dma_req_ready_o stayed high while all groups were stalled");
    end

  a_done_order : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dma_done_o |-> (done_count < xfer_count) && (xfer_left[done_count % MaxXfers] == 0))
    else begin
      error_count++;
      $display("dma_done_o pulsed before the oldest transfer had finished");
    end

  a_drain_busy : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    drain_check |-> !dma_busy_o)
    else begin
      error_count++;
      $display("dma_busy_o still high after all transfers finished");
    end

  for (genvar g = 0; g < NumGroups; g++) begin : gen_grp_checks
    logic hs;

    assign hs          = grp_req_valid_o[g] && grp_req_ready_i[g];
    assign exp_head[g] = exp_mem[g][exp_rd[g] % MaxSlices];

    a_slice_known : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      hs |-> exp_rd[g] < exp_wr[g])
      else begin
        error_count++;
        $display("Group %0d received a slice that was never requested", g);
      end

    a_slice_match : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      hs |-> grp_req_o[g] == exp_head[g])
      else begin
        error_count++;
        $display("Error: grp_req_o[%0d] is %h, expected %h", g,
                 $sampled(grp_req_o[g]), $sampled(exp_head[g]));
      end

    a_slice_route : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      hs |-> grp_req_o[g].dst[5:4] == GroupIdxWidth'(g))
      else begin
        error_count++;
        $display("Error: grp_req_o[%0d].dst is %h, owned by another group", g,
                 $sampled(grp_req_o[g].dst));
      end

    a_slice_bound : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      hs |-> grp_req_o[g].dst[3:0] + grp_req_o[g].len <= SliceBytes)
      else begin
        error_count++;
        $display("Slice on group %0d crosses a group boundary", g);
      end

    a_stall_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      grp_req_valid_o[g] && !grp_req_ready_i[g] |=>
        grp_req_valid_o[g] && $stable(grp_req_o[g]))
      else begin
        error_count++;
        $display("Error: grp_req_o[%0d] is %h while stalled, was %h", g,
                 $sampled(grp_req_o[g]), $past(grp_req_o[g]));
      end

    a_drain_slices : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      drain_check |-> exp_rd[g] == exp_wr[g])
      else begin
        error_count++;
        $display("Group %0d is missing slices after the drain", g);
      end
  end : gen_grp_checks

  // Row pieces first, then group slices inside each piece
  task automatic expect_transfer(input dma_req_t req);
    logic [31:0] src;
    logic [31:0] dst;
    int          left;
    int          piece;
    int          part;
    int          g;
    src  = req.src;
    dst  = req.dst;
    left = int'(req.len);
    while (left > 0) begin
      piece = RowBytes - int'(dst % RowBytes);
      if (left < piece) begin
        piece = left;
      end
      left = left - piece;
      while (piece > 0) begin
        part = SliceBytes - int'(dst % SliceBytes);
        if (piece < part) begin
          part = piece;
        end
        g = int'((dst / SliceBytes) % NumGroups);
        exp_mem[g][exp_wr[g] % MaxSlices]    = '{src: src, dst: dst, len: LenWidth'(part)};
        slice_xfer[g][exp_wr[g] % MaxSlices] = xfer_count % MaxXfers;
        exp_wr[g]++;
        xfer_left[xfer_count % MaxXfers]++;
        slice_total++;
        src   = src + part;
        dst   = dst + part;
        piece = piece - part;
      end
    end
    xfer_count++;
  endtask

  task automatic send_request(input logic [31:0] dst, input int len);
    dma_req_t req;
    req.src         = 32'h8000_0000 | take_bits(stim_lfsr, 20);
    req.dst         = dst;
    req.len         = LenWidth'(len);
    dma_req_i       = req;
    dma_req_valid_i = 1'b1;
    while (!dma_req_ready_o) begin
      @(posedge clk_i);
      #1;
    end
    @(posedge clk_i);
    #1;
    dma_req_valid_i = 1'b0;
    expect_transfer(req);
  endtask

  task automatic set_ready_mode(input int mode);
    @(negedge clk_i);
    ready_mode = mode;
    @(posedge clk_i);
    #1;
  endtask

  // Every requested transfer has been reported done by the DUT
  task automatic wait_drained();
    logic settled;
    settled = 1'b0;
    while (!settled) begin
      @(negedge clk_i);
      settled = (done_count == xfer_count);
      for (int g = 0; g < NumGroups; g++) begin
        if (pending[g] != 0) begin
          settled = 1'b0;
        end
      end
    end
    @(posedge clk_i);
    #1;
    drain_check = 1'b1;
    @(posedge clk_i);
    #1;
    drain_check = 1'b0;
  endtask

  task automatic report_test(input string name);
    tests_run++;
    $display("Test %0d, %s: %0d errors", tests_run, name, error_count - error_base);
    error_base = error_count;
  endtask

  initial begin : stimulus
    logic [31:0] dst;
    stim_lfsr       = 32'hab29_6a6c;
    arst_n_i        = 1'b0;
    dma_req_i       = '0;
    dma_req_valid_i = 1'b0;
    ready_mode      = 0;
    idle_check      = 1'b0;
    bp_end          = 1'b0;
    drain_check     = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    idle_check = 1'b1;
    repeat (8) @(posedge clk_i);
    #1;
    idle_check = 1'b0;
    report_test("idle after reset");

    dst = take_bits(stim_lfsr, 16);
    send_request(dst, 1 + int'(take_bits(stim_lfsr, 4)) % (SliceBytes - dst[3:0]));
    wait_drained();
    report_test("single slice");

    for (int i = 0; i < 8; i++) begin
      send_request(take_bits(stim_lfsr, 15), 1 + int'(take_bits(stim_lfsr, 8)));
    end
    wait_drained();
    report_test("long transfers");

    set_ready_mode(2);
    fork
      for (int i = 0; i < 6; i++) begin
        send_request(take_bits(stim_lfsr, 15), 64 + int'(take_bits(stim_lfsr, 6)));
      end
      begin
        repeat (40) @(posedge clk_i);
        #1;
        bp_end = 1'b1;
        @(posedge clk_i);
        #1;
        bp_end = 1'b0;
        set_ready_mode(0);
      end
    join
    wait_drained();
    report_test("back-pressure");

    set_ready_mode(1);
    for (int i = 0; i < 8; i++) begin
      send_request(take_bits(stim_lfsr, 15), 1 + int'(take_bits(stim_lfsr, 7)));
    end
    wait_drained();
    report_test("transfers in flight");

    $display("Tests run: %0d, errors: %0d", tests_run, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule : tb_dma_cluster_frontend

//--- design/dma_cluster_frontend.sv
// DMA request front end of the cluster
// Input slice, row and group splitting, per-group slices and DMA status
module dma_cluster_frontend (
  input  logic                                           clk_i,
  input  logic                                           arst_n_i,
  input  dma_pkg::dma_req_t                              dma_req_i,
  input  logic                                           dma_req_valid_i,
  output logic                                           dma_req_ready_o,
  output logic                                           dma_busy_o,
  output logic                                           dma_done_o,
  output dma_pkg::dma_req_t [cluster_pkg::NumGroups-1:0] grp_req_o,
  output logic              [cluster_pkg::NumGroups-1:0] grp_req_valid_o,
  input  logic              [cluster_pkg::NumGroups-1:0] grp_req_ready_i,
  input  logic              [cluster_pkg::NumGroups-1:0] grp_done_i
);
  import cluster_pkg::*;
  import dma_pkg::*;

  dma_req_t                 cut_req;
  logic                     cut_valid;
  logic                     cut_ready;
  dma_req_t                 split_req;
  logic                     split_last;
  logic                     split_valid;
  logic                     split_ready;
  dma_req_t [NumGroups-1:0] dist_req;
  logic [NumGroups-1:0]     dist_valid;
  logic [NumGroups-1:0]     dist_ready;
  logic                     issue;
  logic [GroupIdxWidth-1:0] issue_group;
  logic                     issue_last;
  logic                     track_ready;
  logic                     track_busy;

  dma_spill_register in_slice_inst (
    .clk_i   (clk_i          ),
    .arst_n_i(arst_n_i       ),
    .data_i  (dma_req_i      ),
    .valid_i (dma_req_valid_i),
    .ready_o (dma_req_ready_o),
    .data_o  (cut_req        ),
    .valid_o (cut_valid      ),
    .ready_i (cut_ready      )
  );

  dma_row_splitter row_splitter_inst (
    .clk_i   (clk_i      ),
    .arst_n_i(arst_n_i   ),
    .req_i   (cut_req    ),
    .valid_i (cut_valid  ),
    .ready_o (cut_ready  ),
    .req_o   (split_req  ),
    .last_o  (split_last ),
    .valid_o (split_valid),
    .ready_i (split_ready)
  );

  dma_group_distributor group_distributor_inst (
    .clk_i        (clk_i      ),
    .arst_n_i     (arst_n_i   ),
    .req_i        (split_req  ),
    .last_i       (split_last ),
    .valid_i      (split_valid),
    .ready_o      (split_ready),
    .grp_req_o    (dist_req   ),
    .grp_valid_o  (dist_valid ),
    .grp_ready_i  (dist_ready ),
    .issue_o      (issue      ),
    .issue_group_o(issue_group),
    .issue_last_o (issue_last ),
    .track_ready_i(track_ready)
  );

  dma_completion_tracker completion_tracker_inst (
    .clk_i        (clk_i      ),
    .arst_n_i     (arst_n_i   ),
    .issue_i      (issue      ),
    .issue_group_i(issue_group),
    .issue_last_i (issue_last ),
    .ready_o      (track_ready),
    .grp_done_i   (grp_done_i ),
    .busy_o       (track_busy ),
    .done_o       (dma_done_o )
  );

  // Requests not yet opened in the tracker still count as busy
  assign dma_busy_o = track_busy || cut_valid || split_valid || (|dist_valid);

  for (genvar g = 0; g < NumGroups; g++) begin : gen_grp_slice
    dma_spill_register grp_slice_inst (
      .clk_i   (clk_i             ),
      .arst_n_i(arst_n_i          ),
      .data_i  (dist_req[g]       ),
      .valid_i (dist_valid[g]     ),
      .ready_o (dist_ready[g]     ),
      .data_o  (grp_req_o[g]      ),
      .valid_o (grp_req_valid_o[g]),
      .ready_i (grp_req_ready_i[g])
    );
  end : gen_grp_slice

endmodule : dma_cluster_frontend

//--- design/dma_completion_tracker.sv
// DMA completion tracker
// Counts open slices per transfer and group, reports busy and done
module dma_completion_tracker (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic                                  issue_i,
  input  logic [cluster_pkg::GroupIdxWidth-1:0] issue_group_i,
  input  logic                                  issue_last_i,
  output logic                                  ready_o,
  input  logic [cluster_pkg::NumGroups-1:0]     grp_done_i,
  output logic                                  busy_o,
  output logic                                  done_o
);
  import cluster_pkg::*;
  import dma_pkg::*;

  logic [TrackDepth-1:0][NumGroups-1:0][SliceCntWidth-1:0] cnt_q;
  logic [TrackDepth-1:0][NumGroups-1:0][SliceCntWidth-1:0] cnt_d;
  logic [TrackDepth-1:0]    closed_q;
  logic [TrackPtrWidth-1:0] head_q;
  logic [TrackPtrWidth-1:0] tail_q;
  logic [TrackPtrWidth:0]   used_q;
  logic                     open_q;
  logic                     close;
  logic                     head_free;
  logic [NumGroups-1:0]     grp_pending;

  assign close = issue_i && issue_last_i;

  always_comb begin
    logic                     found;
    logic [TrackPtrWidth-1:0] idx;
    cnt_d = cnt_q;
    if (issue_i) begin
      cnt_d[tail_q][issue_group_i] = cnt_q[tail_q][issue_group_i] + 1'b1;
    end
    // Groups finish in order, so a done hits the oldest entry waiting on it
    for (int g = 0; g < NumGroups; g++) begin
      found = 1'b0;
      for (int i = 0; i < TrackDepth; i++) begin
        idx = head_q + TrackPtrWidth'(i);
        if (grp_done_i[g] && !found && (cnt_q[idx][g] != '0)) begin
          cnt_d[idx][g] = cnt_d[idx][g] - 1'b1;
          found = 1'b1;
        end
      end
    end
  end

  // Freed on the done that empties it, so done_o lands one cycle later
  assign head_free = closed_q[head_q] && (cnt_d[head_q] == '0);

  assign ready_o = (used_q < TrackDepth);
  assign busy_o  = (used_q != '0) || open_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q    <= '0;
      closed_q <= '0;
      head_q   <= '0;
      tail_q   <= '0;
      used_q   <= '0;
      open_q   <= 1'b0;
      done_o   <= 1'b0;
    end else begin
      cnt_q  <= cnt_d;
      done_o <= head_free;
      if (issue_i) begin
        open_q <= !issue_last_i;
      end
      if (close) begin
        closed_q[tail_q] <= 1'b1;
        tail_q           <= tail_q + 1'b1;
      end
      if (head_free) begin
        closed_q[head_q] <= 1'b0;
        head_q           <= head_q + 1'b1;
      end
      if (close && !head_free) begin
        used_q <= used_q + 1'b1;
      end else if (!close && head_free) begin
        used_q <= used_q - 1'b1;
      end
    end
  end

  always_comb begin
    grp_pending = '0;
    for (int i = 0; i < TrackDepth; i++) begin
      for (int g = 0; g < NumGroups; g++) begin
        if (cnt_q[i][g] != '0) begin
          grp_pending[g] = 1'b1;
        end
      end
    end
  end

  // Group back ends only finish slices they were given
  a_done_has_slice : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (grp_done_i & ~grp_pending) == '0)
    else $error("Done pulse from a group with no outstanding DMA slice");

endmodule : dma_completion_tracker

//--- design/dma_group_distributor.sv
// DMA group distributor
// Walks a row piece slice by slice and steers each slice to its owning group
module dma_group_distributor (
  input  logic                                                 clk_i,
  input  logic                                                 arst_n_i,
  input  dma_pkg::dma_req_t                                    req_i,
  input  logic                                                 last_i,
  input  logic                                                 valid_i,
  output logic                                                 ready_o,
  output dma_pkg::dma_req_t [cluster_pkg::NumGroups-1:0]       grp_req_o,
  output logic              [cluster_pkg::NumGroups-1:0]       grp_valid_o,
  input  logic              [cluster_pkg::NumGroups-1:0]       grp_ready_i,
  output logic                                                 issue_o,
  output logic              [cluster_pkg::GroupIdxWidth-1:0]   issue_group_o,
  output logic                                                 issue_last_o,
  input  logic                                                 track_ready_i
);
  import cluster_pkg::*;
  import dma_pkg::*;

  dma_req_t            piece_q;
  logic                last_q;
  logic                busy_q;
  tcdm_addr_u          dst_u;
  logic [LenWidth-1:0] slice_room;
  logic [LenWidth-1:0] slice_len;
  logic                slice_final;
  dma_req_t            slice_req;
  logic                handshake;

  assign dst_u = piece_q.dst;

  // Slice ends at the next group boundary or at the end of the piece
  assign slice_room  = LenWidth'(SliceBytes) - LenWidth'(dst_u.fields.offset);
  assign slice_final = (piece_q.len <= slice_room);
  assign slice_len   = slice_final ? piece_q.len : slice_room;
  assign slice_req   = '{src: piece_q.src, dst: piece_q.dst, len: slice_len};

  // All groups see the slice, only the owner gets valid
  assign grp_req_o = {NumGroups{slice_req}};

  always_comb begin
    grp_valid_o = '0;
    if (busy_q && track_ready_i) begin
      grp_valid_o[dst_u.fields.group] = 1'b1;
    end
  end

  assign handshake     = |(grp_valid_o & grp_ready_i);
  assign issue_o       = handshake;
  assign issue_group_o = dst_u.fields.group;
  assign issue_last_o  = slice_final && last_q;

  // Next piece loads as the final slice leaves
  assign ready_o = !busy_q || (handshake && slice_final);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
    end else if (ready_o) begin
      busy_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      piece_q <= req_i;
      last_q  <= last_i;
    end else if (handshake) begin
      piece_q.src <= piece_q.src + AddrWidth'(slice_len);
      piece_q.dst <= piece_q.dst + AddrWidth'(slice_len);
      piece_q.len <= piece_q.len - slice_len;
    end
  end

  a_one_group : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(grp_valid_o))
    else $error("DMA slice offered to more than one group");

endmodule : dma_group_distributor

//--- design/dma_row_splitter.sv
// DMA row splitter
// Cuts a transfer into pieces that stay within one cluster row of the TCDM
module dma_row_splitter (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  dma_pkg::dma_req_t req_i,
  input  logic              valid_i,
  output logic              ready_o,
  output dma_pkg::dma_req_t req_o,
  output logic              last_o,
  output logic              valid_o,
  input  logic              ready_i
);
  import cluster_pkg::*;
  import dma_pkg::*;

  dma_req_t            rem_q;
  logic                busy_q;
  tcdm_addr_u          dst_u;
  logic [LenWidth-1:0] row_room;
  logic [LenWidth-1:0] piece_len;
  logic                load;
  logic                advance;

  assign dst_u = rem_q.dst;

  // Bytes left before the destination enters the next row
  assign row_room  = LenWidth'(RowBytes) - LenWidth'(dst_u.word[$clog2(RowBytes)-1:0]);
  assign last_o    = (rem_q.len <= row_room);
  assign piece_len = last_o ? rem_q.len : row_room;

  assign req_o   = '{src: rem_q.src, dst: rem_q.dst, len: piece_len};
  assign valid_o = busy_q;
  assign advance = valid_o && ready_i;
  assign load    = valid_i && !busy_q;

  // Request leaves the input slice with its last piece
  assign ready_o = advance && last_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
    end else if (load) begin
      busy_q <= 1'b1;
    end else if (ready_o) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      rem_q <= req_i;
    end else if (advance) begin
      rem_q.src <= rem_q.src + AddrWidth'(piece_len);
      rem_q.dst <= rem_q.dst + AddrWidth'(piece_len);
      rem_q.len <= rem_q.len - piece_len;
    end
  end

  // Transfers must be non-empty and land fully inside the TCDM
  a_req_in_tcdm : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    load |-> (req_i.len != '0) && (req_i.dst >= TcdmBaseAddr) &&
             (33'(req_i.dst) + 33'(req_i.len) <= 33'(TcdmBaseAddr) + 33'(TcdmSize)))
    else $error("DMA destination outside the TCDM or zero length");

endmodule : dma_row_splitter

//--- design/dma_spill_register.sv
// DMA request register slice
// Two entries, so neither valid nor ready crosses the slice combinationally
module dma_spill_register (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  dma_pkg::dma_req_t data_i,
  input  logic              valid_i,
  output logic              ready_o,
  output dma_pkg::dma_req_t data_o,
  output logic              valid_o,
  input  logic              ready_i
);
  import dma_pkg::*;

  dma_req_t a_data_q;
  dma_req_t b_data_q;
  logic     a_full_q;
  logic     b_full_q;
  logic     en_q;
  logic     a_fill;
  logic     a_drain;
  logic     b_fill;
  logic     b_drain;

  // A takes new requests, B parks the older one on a stall
  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  assign valid_o = a_full_q || b_full_q;
  assign ready_o = en_q && (!a_full_q || !b_full_q);
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_q     <= 1'b0;
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      en_q <= 1'b1;
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  a_out_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o))
    else $error("Stalled DMA request changed or vanished");

endmodule : dma_spill_register

//--- design/dma_pkg.sv
// DMA request format
// Request struct, TCDM address views and completion tracker sizing
package dma_pkg;

  localparam int unsigned LenWidth = 16;

  typedef struct packed {
    logic [cluster_pkg::AddrWidth-1:0] src;
    logic [cluster_pkg::AddrWidth-1:0] dst;
    logic [LenWidth-1:0]               len;
  } dma_req_t;

  localparam int unsigned OffsetWidth = $clog2(cluster_pkg::SliceBytes);
  localparam int unsigned RowIdxWidth =
      cluster_pkg::AddrWidth - cluster_pkg::GroupIdxWidth - OffsetWidth;

  // Routing view of a destination address
  typedef struct packed {
    logic [RowIdxWidth-1:0]                row;
    logic [cluster_pkg::GroupIdxWidth-1:0] group;
    logic [OffsetWidth-1:0]                offset;
  } tcdm_fields_t;

  // Flat word for range and boundary math, fields for steering
  typedef union packed {
    logic [cluster_pkg::AddrWidth-1:0] word;
    tcdm_fields_t                      fields;
  } tcdm_addr_u;

  // Transfers in flight at once
  localparam int unsigned TrackDepth    = 4;
  localparam int unsigned TrackPtrWidth = $clog2(TrackDepth);
  localparam int unsigned SliceCntWidth = 12;

endpackage : dma_pkg

//--- design/cluster_pkg.sv
// Cluster geometry
// Group, bank and row sizes of the word-interleaved TCDM
package cluster_pkg;

  localparam int unsigned NumGroups        = 4;
  localparam int unsigned GroupIdxWidth    = $clog2(NumGroups);
  localparam int unsigned NumBanksPerGroup = 4;
  localparam int unsigned BankBytes        = 4;

  // Bytes one group owns in every cluster row
  localparam int unsigned SliceBytes       = NumBanksPerGroup * BankBytes;
  localparam int unsigned RowBytes         = SliceBytes * NumGroups;

  localparam int unsigned AddrWidth        = 32;

  // TCDM region
  localparam logic [AddrWidth-1:0] TcdmBaseAddr = 32'h0000_0000;
  localparam int unsigned          TcdmSize     = 32'h0001_0000;

endpackage : cluster_pkg
